// File: gnn_fv.f
+incdir+include
design/fv_pkg.sv
design/fv_sram.sv
design/fv_bank_ctrl.sv
design/fv_dispatch.sv
design/fv_collect.sv
design/fv_mem_top.sv
bench/fv_mem_tb.sv

// File: bench/fv_mem_tb.sv
// Testbench for the feature-vector memory that loads banks over Wishbone and checks PE streams.
`timescale 1ns/1ps
`include "fv_consts.svh"

module fv_mem_tb;

    localparam int VEC_WORDS  = 32;  // Words loaded into every bank, starting at word 0.
    localparam int LOAD_WORDS = `FV_NUM_BANKS * VEC_WORDS;
    localparam int NUM_RAND   = 12;
    localparam int NUM_REQ    = 6 + NUM_RAND;
    localparam int WDOG_CYC   = 16 + LOAD_WORDS * 4 + NUM_REQ * 200;

    logic                              clk;
    logic                              reset;
    fv_pkg::wb_req_t                   wb_req;
    fv_pkg::wb_rsp_t                   wb_rsp;
    fv_pkg::fv_beat_t [`FV_NUM_PE-1:0] pe_beat;

    int                       errors;
    int                       num_issued;
    logic [31:0]              lfsr;
    logic [1:0]               quiet_q;      // Reset seen in one of the last two cycles.
    logic [`FV_DATA_W-1:0]    shadow [`FV_NUM_BANKS][1 << `FV_ADDR_W];
    int                       exp_start [`FV_NUM_PE];
    int                       exp_n [`FV_NUM_PE];
    int                       exp_bank [`FV_NUM_PE];
    int                       seen [`FV_NUM_PE];  // Beats already received on each PE.
    logic [`FV_NUM_PE-1:0]    active;
    logic [`FV_NUM_PE-1:0]    pe_valid;
    logic [`FV_NUM_BANKS-1:0] bank_exp;
    logic                     req_blocked;
    logic                     stat_ack;
    logic                     req_ack;

    fv_mem_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .pe_beat (pe_beat)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
    endfunction

    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string what);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, what);
    endtask

    task automatic wait_ack();
        do @(posedge clk); while (!wb_rsp.ack);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: dat};
        wait_ack();
    endtask

    task automatic read_status(output logic [31:0] word);
        @(posedge clk);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: `WB_STAT_ADR, dat_w: '0};
        wait_ack();
        word = wb_rsp.dat_r;
    endtask

    task automatic load_banks();
        logic [31:0] data;
        logic        last;
        for (int b = 0; b < `FV_NUM_BANKS; b++) begin
            for (int w = 0; w < VEC_WORDS; w++) begin
                draw_bits(16, data);
                last = (w == VEC_WORDS - 1);
                shadow[b][w] = data[15:0];
                wb_write({6'd0, b[1:0], w[7:0]}, {15'd0, last, data[15:0]});
            end
        end
    endtask

    // The stream checker of the PE is armed at the clock edge that ends the ack.
    task automatic issue_req(input int bank, input int tag, input int start, input int n);
        logic [31:0] dat;
        dat        = '0;
        dat[7:0]   = start[7:0];
        dat[14:8]  = n[6:0];
        dat[17:16] = bank[1:0];
        dat[21:20] = tag[1:0];
        wb_write(`WB_REQ_ADR, dat);
        exp_start[tag] <= start;
        exp_n[tag]     <= n;
        exp_bank[tag]  <= bank;
        seen[tag]      <= 0;
        active[tag]    <= 1'b1;
        num_issued++;
    endtask

    // A request armed in this time step only shows in active after the next edge.
    task automatic wait_idle();
        do @(posedge clk); while (active != '0);
    endtask

    task automatic run_random(input int count);
        logic [31:0] bank;
        logic [31:0] tag;
        logic [31:0] n;
        logic [31:0] start;
        logic [31:0] word;
        for (int i = 0; i < count; i++) begin
            draw_bits(2, bank);
            draw_bits(2, tag);
            draw_bits(6, n);
            draw_bits(5, start);
            n     = n + 1;
            start = start % (VEC_WORDS + 1 - (n + 1) / 2);  // Stream stays inside loaded words.
            issue_req(bank, tag, start, n);
            if (i % 3 == 2) begin
                read_status(word);
            end
        end
    endtask

    always @(posedge clk) begin
        quiet_q <= {quiet_q[0], reset};
        for (int p = 0; p < `FV_NUM_PE; p++) begin
            if (!reset && pe_beat[p].valid) begin
                seen[p] <= seen[p] + 1;
                if (pe_beat[p].eos) begin
                    active[p] <= 1'b0;
                end
            end
        end
    end

    // A bank is free once its last beat has left it, one cycle before the PE sees it.
    always_comb begin
        bank_exp = '0;
        for (int p = 0; p < `FV_NUM_PE; p++) begin
            pe_valid[p] = pe_beat[p].valid;
            if (active[p] && !(pe_beat[p].valid && pe_beat[p].eos)) begin
                bank_exp[exp_bank[p]] = 1'b1;
            end
        end
        req_blocked = bank_exp[wb_req.dat_w[17:16]] || active[wb_req.dat_w[21:20]];
        stat_ack    = wb_rsp.ack && wb_req.cyc && !wb_req.we && (wb_req.adr == `WB_STAT_ADR);
        req_ack     = wb_rsp.ack && wb_req.cyc && wb_req.we && (wb_req.adr == `WB_REQ_ADR);
    end

    a_reset_quiet: assert property (@(posedge clk) (quiet_q != '0) |-> !wb_rsp.ack && !pe_valid)
        else report_mismatch("ack or a PE beat active around reset");

    a_status: assert property (@(posedge clk) disable iff (reset)
        stat_ack |-> (wb_rsp.dat_r[3:0] == $past(bank_exp)) && (wb_rsp.dat_r[7:4] == $past(active)))
        else report_mismatch("status word differs from the requests in flight");

    a_req_stall: assert property (@(posedge clk) disable iff (reset) req_ack |-> !$past(req_blocked))
        else report_mismatch("request acked while its bank or PE was busy");

    for (genvar p = 0; p < `FV_NUM_PE; p++) begin : g_chk
        logic [`FV_DATA_W-1:0] exp_data;
        logic                  last;
        logic                  odd;

        always_comb begin
            last     = (seen[p] == (exp_n[p] + 1) / 2 - 1);
            odd      = (exp_n[p] % 2 == 1);
            exp_data = shadow[exp_bank[p]][(exp_start[p] + seen[p]) % 256];
            if (last && odd) begin
                exp_data[15:8] = '0;
            end
        end

        a_armed: assert property (@(posedge clk) disable iff (reset)
            pe_beat[p].valid |-> active[p])
            else report_mismatch($sformatf("PE %0d beat without a request", p));
        a_tag: assert property (@(posedge clk) disable iff (reset)
            pe_beat[p].valid |-> (pe_beat[p].pe_tag == p))
            else report_mismatch($sformatf("PE %0d beat has tag %0d", p, pe_beat[p].pe_tag));
        a_data: assert property (@(posedge clk) disable iff (reset)
            pe_beat[p].valid |-> (pe_beat[p].data == exp_data))
            else report_mismatch($sformatf("PE %0d beat %0d data %h, expected %h",
                                           p, seen[p], pe_beat[p].data, exp_data));
        a_frame: assert property (@(posedge clk) disable iff (reset)
            pe_beat[p].valid |-> (pe_beat[p].sos == (seen[p] == 0)) && (pe_beat[p].eos == last))
            else report_mismatch($sformatf("PE %0d beat %0d has wrong sos or eos", p, seen[p]));
        a_gapless: assert property (@(posedge clk) disable iff (reset)
            pe_beat[p].valid && !pe_beat[p].eos |=> pe_beat[p].valid)
            else report_mismatch($sformatf("PE %0d stream has a gap", p));
        a_odd_zero: assert property (@(posedge clk) disable iff (reset)
            pe_beat[p].valid && pe_beat[p].eos && odd |-> (pe_beat[p].data[15:8] == '0))
            else report_mismatch($sformatf("PE %0d odd stream high byte not zero", p));
    end

    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("Timeout: the streams did not finish within %0d cycles.", WDOG_CYC);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [31:0] word;
        wb_req     = '0;
        reset      = 1'b1;
        errors     = 0;
        num_issued = 0;
        lfsr       = 32'h6af3;
        quiet_q    = '0;
        active     = '0;
        for (int p = 0; p < `FV_NUM_PE; p++) begin
            exp_start[p] = 0;
            exp_n[p]     = 1;
            exp_bank[p]  = 0;
            seen[p]      = 0;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        load_banks();
        issue_req(0, 0, 0, 1);   // One feature gives one beat with both flags.
        issue_req(1, 1, 5, 2);
        wait_idle();
        issue_req(2, 2, 3, 37);  // Two banks stream to two PEs at once.
        issue_req(3, 3, 0, 64);
        read_status(word);
        issue_req(2, 0, 1, 9);   // Held off while bank 2 is busy.
        issue_req(0, 3, 4, 20);  // Held off while PE 3 is busy.
        read_status(word);
        wait_idle();
        run_random(NUM_RAND);
        wait_idle();
        read_status(word);
        $display("Requests issued: %0d, errors: %0d", num_issued, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: design/fv_mem_top.sv
// Feature-vector memory top with the Wishbone dispatcher, the SRAM banks and the PE collector.
`timescale 1ns/1ps
`include "fv_consts.svh"

module fv_mem_top (
    input  logic                              clk,
    input  logic                              reset,
    input  fv_pkg::wb_req_t                   wb_req,
    output fv_pkg::wb_rsp_t                   wb_rsp,
    output fv_pkg::fv_beat_t [`FV_NUM_PE-1:0] pe_beat
);

    fv_pkg::fv_load_t [`FV_NUM_BANKS-1:0] load;
    fv_pkg::fv_req_t  [`FV_NUM_BANKS-1:0] req;
    fv_pkg::fv_beat_t [`FV_NUM_BANKS-1:0] bank_beat;
    logic [`FV_NUM_BANKS-1:0]             bank_busy;
    logic [`FV_NUM_PE-1:0]                pe_done;

    fv_dispatch dispatch_i (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .load      (load),
        .req       (req),
        .bank_busy (bank_busy),
        .pe_done   (pe_done)
    );

    for (genvar b = 0; b < `FV_NUM_BANKS; b++) begin : g_bank
        fv_pkg::fv_sram_req_t  sram_req;
        logic [`FV_DATA_W-1:0] sram_q;

        fv_bank_ctrl bank_ctrl_i (
            .clk      (clk),
            .reset    (reset),
            .load     (load[b]),
            .req      (req[b]),
            .sram_q   (sram_q),
            .sram_req (sram_req),
            .beat     (bank_beat[b]),
            .busy     (bank_busy[b])
        );

        fv_sram sram_i (
            .clk (clk),
            .req (sram_req),
            .q   (sram_q)
        );
    end

    fv_collect collect_i (
        .clk       (clk),
        .reset     (reset),
        .bank_beat (bank_beat),
        .pe_beat   (pe_beat),
        .pe_done   (pe_done)
    );

endmodule

// File: design/fv_collect.sv
// Collector that steers bank stream beats to the edge PE ports by their PE tag.
`timescale 1ns/1ps
`include "fv_consts.svh"

module fv_collect (
    input  logic                                 clk,
    input  logic                                 reset,
    input  fv_pkg::fv_beat_t [`FV_NUM_BANKS-1:0] bank_beat,
    output fv_pkg::fv_beat_t [`FV_NUM_PE-1:0]    pe_beat,
    output logic [`FV_NUM_PE-1:0]                pe_done
);

    localparam int TAG_W = $clog2(`FV_NUM_PE);

    fv_pkg::fv_beat_t [`FV_NUM_PE-1:0] pe_beat_nx;
    logic                              tag_clash;

    // At most one bank carries a given tag, so the match needs no priority.
    always_comb begin
        for (int p = 0; p < `FV_NUM_PE; p++) begin
            pe_beat_nx[p] = '0;
            for (int b = 0; b < `FV_NUM_BANKS; b++) begin
                if (bank_beat[b].valid && (bank_beat[b].pe_tag == TAG_W'(p))) begin
                    pe_beat_nx[p] = bank_beat[b];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pe_beat <= '0;
            pe_done <= '0;
        end else begin
            pe_beat <= pe_beat_nx;
            for (int p = 0; p < `FV_NUM_PE; p++) begin
                pe_done[p] <= pe_beat_nx[p].valid && pe_beat_nx[p].eos;  // Same cycle as eos.
            end
        end
    end

    always_comb begin
        tag_clash = 1'b0;
        for (int i = 0; i < `FV_NUM_BANKS; i++) begin
            for (int j = i + 1; j < `FV_NUM_BANKS; j++) begin
                if (bank_beat[i].valid && bank_beat[j].valid &&
                    (bank_beat[i].pe_tag == bank_beat[j].pe_tag)) begin
                    tag_clash = 1'b1;
                end
            end
        end
    end

    // The dispatcher keeps a PE busy from request to done, so two banks never share one.
    a_no_tag_clash: assert property (@(posedge clk) disable iff (reset) !tag_clash);

endmodule

// File: design/fv_dispatch.sv
// Wishbone slave that turns host writes into bank load beats and stream requests.
`timescale 1ns/1ps
`include "fv_consts.svh"

module fv_dispatch (
    input  logic                                 clk,
    input  logic                                 reset,
    input  fv_pkg::wb_req_t                      wb_req,
    output fv_pkg::wb_rsp_t                      wb_rsp,
    output fv_pkg::fv_load_t [`FV_NUM_BANKS-1:0] load,
    output fv_pkg::fv_req_t  [`FV_NUM_BANKS-1:0] req,
    input  logic [`FV_NUM_BANKS-1:0]             bank_busy,
    input  logic [`FV_NUM_PE-1:0]                pe_done
);

    localparam int BANK_W = $clog2(`FV_NUM_BANKS);
    localparam int TAG_W  = $clog2(`FV_NUM_PE);

    logic                                 sel;        // Cycle in progress and not yet acked.
    logic                                 is_load;
    logic                                 is_req;
    logic                                 is_stat;
    logic [BANK_W-1:0]                    ld_bank;
    logic [BANK_W-1:0]                    rq_bank;
    logic [TAG_W-1:0]                     rq_tag;
    logic                                 stall;
    logic                                 fire_load;
    logic                                 fire_req;
    logic [`FV_NUM_BANKS-1:0]             open_load;  // Bank sits between sos and eos of a load.
    logic [`FV_NUM_BANKS-1:0]             req_pend;
    logic [`FV_NUM_BANKS-1:0]             bank_stat;
    logic [`FV_NUM_PE-1:0]                pe_busy;
    logic [`WB_DAT_W-1:0]                 stat_word;
    fv_pkg::fv_load_t [`FV_NUM_BANKS-1:0] load_nx;
    fv_pkg::fv_req_t  [`FV_NUM_BANKS-1:0] req_nx;

    assign sel     = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign is_load = !wb_req.adr[`WB_ADR_W-1];
    assign is_req  = (wb_req.adr == `WB_REQ_ADR);
    assign is_stat = (wb_req.adr == `WB_STAT_ADR);
    assign ld_bank = wb_req.adr[`FV_ADDR_W +: BANK_W];
    assign rq_bank = wb_req.dat_w[16 +: BANK_W];
    assign rq_tag  = wb_req.dat_w[20 +: TAG_W];

    // The master still holds its request during the ack cycle.
    assign fire_load = wb_rsp.ack && wb_req.cyc && wb_req.stb && wb_req.we && is_load;
    assign fire_req  = wb_rsp.ack && wb_req.cyc && wb_req.stb && wb_req.we && is_req;

    // A request sent last cycle has not yet raised its bank's busy.
    always_comb begin
        for (int b = 0; b < `FV_NUM_BANKS; b++) begin
            req_pend[b] = req[b].valid;
        end
    end

    assign bank_stat = bank_busy | req_pend;

    always_comb begin
        stall = 1'b0;
        if (wb_req.we && is_req) begin
            stall = bank_stat[rq_bank] || open_load[rq_bank] || pe_busy[rq_tag];
        end else if (wb_req.we && is_load) begin
            stall = (bank_busy[ld_bank] && !open_load[ld_bank]) || req_pend[ld_bank];
        end
    end

    always_comb begin
        stat_word                              = '0;
        stat_word[0 +: `FV_NUM_BANKS]          = bank_stat;
        stat_word[`FV_NUM_BANKS +: `FV_NUM_PE] = pe_busy;
    end

    always_comb begin
        load_nx = load;
        req_nx  = req;
        for (int b = 0; b < `FV_NUM_BANKS; b++) begin
            load_nx[b].valid = 1'b0;
            req_nx[b].valid  = 1'b0;
        end
        if (fire_load) begin
            load_nx[ld_bank] = '{valid: 1'b1, sos: !open_load[ld_bank],
                                 eos: wb_req.dat_w[`FV_DATA_W],
                                 addr: wb_req.adr[`FV_ADDR_W-1:0],
                                 data: wb_req.dat_w[`FV_DATA_W-1:0]};
        end
        if (fire_req) begin
            req_nx[rq_bank] = '{valid: 1'b1, addr: wb_req.dat_w[`FV_ADDR_W-1:0],
                                num_fv: wb_req.dat_w[`FV_ADDR_W +: `FV_CNT_W], pe_tag: rq_tag};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_rsp    <= '0;
            load      <= '0;
            req       <= '0;
            open_load <= '0;
            pe_busy   <= '0;
        end else begin
            wb_rsp.ack   <= sel && !stall;
            wb_rsp.dat_r <= (is_stat && !wb_req.we) ? stat_word : '0;
            load         <= load_nx;
            req          <= req_nx;
            if (fire_load) begin
                open_load[ld_bank] <= !wb_req.dat_w[`FV_DATA_W];
            end
            pe_busy <= pe_busy & ~pe_done;
            if (fire_req) begin
                pe_busy[rq_tag] <= 1'b1;
            end
        end
    end

    // A classic master keeps cyc and stb up until it has seen the ack.
    a_req_held: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

endmodule

// File: design/fv_bank_ctrl.sv
// Bank controller that writes host load beats into its SRAM and streams stored vectors out.
`timescale 1ns/1ps
`include "fv_consts.svh"

module fv_bank_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  fv_pkg::fv_load_t      load,
    input  fv_pkg::fv_req_t       req,
    input  logic [`FV_DATA_W-1:0] sram_q,
    output fv_pkg::fv_sram_req_t  sram_req,
    output fv_pkg::fv_beat_t      beat,
    output logic                  busy
);

    localparam int TAG_W  = $clog2(`FV_NUM_PE);
    localparam int HALF_W = `FV_DATA_W / 2;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_STREAM = 2'd1,
        ST_WRITE  = 2'd2
    } state_t;

    // Framing that travels with one SRAM read until its data returns.
    typedef struct packed {
        logic valid;
        logic sos;
        logic eos;
    } rd_frame_t;

    state_t               state;
    state_t               state_nx;
    fv_pkg::fv_sram_req_t sram_req_nx;
    fv_pkg::fv_beat_t     beat_nx;
    rd_frame_t            rd_issue;     // Lines up with sram_req.
    rd_frame_t            rd_issue_nx;
    rd_frame_t            rd_data;      // Lines up with sram_q.
    logic [TAG_W-1:0]     pe_tag;
    logic [TAG_W-1:0]     pe_tag_nx;
    logic [`FV_CNT_W-1:0] num_fv;
    logic [`FV_CNT_W-1:0] num_fv_nx;
    logic [`FV_CNT_W-1:0] fv_cnt;       // Features covered by the reads issued so far.
    logic [`FV_CNT_W-1:0] fv_cnt_nx;

    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            sram_req <= '{cen: 1'b1, wen: 1'b1, default: '0};
            beat     <= '0;
            rd_issue <= '0;
            rd_data  <= '0;
        end else begin
            state    <= state_nx;
            sram_req <= sram_req_nx;
            beat     <= beat_nx;
            rd_issue <= rd_issue_nx;
            rd_data  <= rd_issue;
        end
    end

    always_ff @(posedge clk) begin
        pe_tag <= pe_tag_nx;
        num_fv <= num_fv_nx;
        fv_cnt <= fv_cnt_nx;
    end

    always_comb begin
        state_nx        = state;
        sram_req_nx     = sram_req;
        sram_req_nx.cen = 1'b1;
        sram_req_nx.wen = 1'b1;
        rd_issue_nx     = '0;
        pe_tag_nx       = pe_tag;
        num_fv_nx       = num_fv;
        fv_cnt_nx       = fv_cnt;
        case (state)
            ST_IDLE: begin
                if (load.valid) begin
                    sram_req_nx = '{cen: 1'b0, wen: 1'b0, a: load.addr, d: load.data};
                    state_nx    = load.eos ? ST_IDLE : ST_WRITE;  // One-word vectors stay idle.
                end else if (req.valid) begin
                    sram_req_nx.cen = 1'b0;
                    sram_req_nx.a   = req.addr;
                    rd_issue_nx     = '{valid: 1'b1, sos: 1'b1, eos: (req.num_fv <= 7'd2)};
                    pe_tag_nx       = req.pe_tag;
                    num_fv_nx       = req.num_fv;
                    fv_cnt_nx       = 7'd2;
                    state_nx        = ST_STREAM;
                end
            end
            ST_WRITE: begin
                // Gaps between host writes leave the array deselected.
                if (load.valid) begin
                    sram_req_nx = '{cen: 1'b0, wen: 1'b0, a: load.addr, d: load.data};
                    if (load.eos) begin
                        state_nx = ST_IDLE;
                    end
                end
            end
            ST_STREAM: begin
                if (fv_cnt < num_fv) begin
                    sram_req_nx.cen = 1'b0;
                    sram_req_nx.a   = sram_req.a + 1'b1;
                    rd_issue_nx     = '{valid: 1'b1, sos: 1'b0, eos: (fv_cnt + 7'd2 >= num_fv)};
                    fv_cnt_nx       = fv_cnt + 7'd2;
                end
                if (beat.valid && beat.eos) begin
                    state_nx = ST_IDLE;  // Busy falls right after the last beat has left.
                end
            end
            default: begin
                state_nx = ST_IDLE;
            end
        endcase
    end

    always_comb begin
        beat_nx.valid  = rd_data.valid;
        beat_nx.sos    = rd_data.sos;
        beat_nx.eos    = rd_data.eos;
        beat_nx.pe_tag = pe_tag;
        beat_nx.data   = sram_q;
        // An odd count leaves the last word with only its low feature.
        if (rd_data.eos && num_fv[0]) begin
            beat_nx.data[`FV_DATA_W-1:HALF_W] = '0;
        end
    end

    // The dispatcher only sends a request to an idle bank, and the host asks for 1 to max features.
    a_req_when_idle: assert property (@(posedge clk) disable iff (reset)
        req.valid |-> (state == ST_IDLE) && (req.num_fv != '0) && (req.num_fv <= `FV_MAX_FV));

endmodule

// File: design/fv_sram.sv
// Single-port feature SRAM with active-low chip and write enables and a registered read.
`timescale 1ns/1ps
`include "fv_consts.svh"

module fv_sram (
    input  logic                  clk,
    input  fv_pkg::fv_sram_req_t  req,
    output logic [`FV_DATA_W-1:0] q
);

    localparam int DEPTH = 1 << `FV_ADDR_W;

    logic [`FV_DATA_W-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (!req.cen) begin
            if (!req.wen) begin
                mem[req.a] <= req.d;
            end else begin
                q <= mem[req.a];  // Read data shows up one cycle after the request.
            end
        end
    end

    // The bank controller must present a clean address whenever the array is selected.
    a_addr_known: assert property (@(posedge clk) !req.cen |-> !$isunknown(req.a));

endmodule

// File: design/fv_pkg.sv
// Shared packed structs that carry load beats, stream requests, SRAM ports and Wishbone traffic.
`include "fv_consts.svh"

package fv_pkg;

    typedef struct packed {
        logic                  valid;
        logic                  sos;    // First word of a vector.
        logic                  eos;    // Last word of a vector.
        logic [`FV_ADDR_W-1:0] addr;
        logic [`FV_DATA_W-1:0] data;
    } fv_load_t;

    typedef struct packed {
        logic                          valid;
        logic [`FV_ADDR_W-1:0]         addr;   // Start word.
        logic [`FV_CNT_W-1:0]          num_fv;
        logic [$clog2(`FV_NUM_PE)-1:0] pe_tag;
    } fv_req_t;

    // Both enables are active low.
    typedef struct packed {
        logic                  cen;
        logic                  wen;
        logic [`FV_ADDR_W-1:0] a;
        logic [`FV_DATA_W-1:0] d;
    } fv_sram_req_t;

    typedef struct packed {
        logic                          valid;
        logic                          sos;
        logic                          eos;
        logic [$clog2(`FV_NUM_PE)-1:0] pe_tag;
        logic [`FV_DATA_W-1:0]         data;   // Two features, low byte first.
    } fv_beat_t;

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [`WB_ADR_W-1:0] adr;
        logic [`WB_DAT_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`WB_DAT_W-1:0] dat_r;
    } wb_rsp_t;

endpackage

// File: include/fv_consts.svh
// Feature-vector memory constants for bank sizes, stream limits and the Wishbone address map.
`ifndef FV_CONSTS_SVH
`define FV_CONSTS_SVH

`define FV_NUM_BANKS 4
`define FV_NUM_PE    4
`define FV_ADDR_W    8
`define FV_DATA_W    16
`define FV_MAX_FV    64
`define FV_CNT_W     7

`define WB_ADR_W     16
`define WB_DAT_W     32

// Register addresses. Address bit 15 low selects the load region instead.
`define WB_REQ_ADR   16'h8000
`define WB_STAT_ADR  16'h8004

`endif
